/* files.f */
+incdir+source
source/periph_pkg.sv
source/mem_bus_if.sv
source/reg_bus_if.sv
source/periph_regbus_demux.sv
source/outstanding_tracker.sv
source/bus_err_unit.sv
source/irq_ctrl.sv
source/safety_periph_top.sv
verification/periph_checker.sv
verification/tb_safety_periph.sv

/* verification/tb_safety_periph.sv */
// Table driven testbench; bus addresses and ext patterns come from an LCG with a fixed seed
`timescale 1ns/10ps
`include "periph_defines.svh"

module tb_safety_periph;

  localparam int IRQ_TIMEOUT = 20;
  localparam logic [31:0] IRQ_WIN   = `PERIPH_BASE_ADDR + `IRQ_CTRL_OFFSET;
  localparam logic [31:0] INSTR_WIN = `PERIPH_BASE_ADDR + `INSTR_ERR_OFFSET;
  localparam logic [31:0] DATA_WIN  = `PERIPH_BASE_ADDR + `DATA_ERR_OFFSET;

  typedef enum logic [3:0] {
    OP_READ, OP_READ_ERR, OP_WRITE, OP_DATA_ACCEPT, OP_DATA_DONE, OP_INSTR_ACCEPT,
    OP_INSTR_DONE, OP_EXT, OP_ACK, OP_IDLE_CHECK, OP_NO_IRQ, OP_WAIT_IRQ
  } op_e;

  typedef struct packed {
    op_e         op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [1:0]  err;
    logic [31:0] exp;
  } row_t;

  logic clk_i;
  logic rst_n_i;
  logic reg_valid_i;
  logic reg_write_i;
  logic [31:0] reg_addr_i;
  logic [31:0] reg_wdata_i;
  logic instr_req_i;
  logic instr_gnt_i;
  logic instr_rvalid_i;
  logic [31:0] instr_addr_i;
  logic [`BUS_ERR_BITS-1:0] instr_err_i;
  logic data_req_i;
  logic data_gnt_i;
  logic data_rvalid_i;
  logic [31:0] data_addr_i;
  logic [`BUS_ERR_BITS-1:0] data_err_i;
  logic [1:0] timer_irqs_i;
  logic [`NUM_EXT_IRQ-1:0] ext_irqs_i;
  logic irq_ack_i;
  logic [31:0] reg_rdata_o;
  logic reg_ready_o;
  logic reg_error_o;
  logic [`NUM_IRQ_SRC-1:0] core_irq_o;
  logic [`IRQ_ID_W-1:0] irq_id_o;
  logic irq_valid_o;

  logic read_chk;
  logic rderr_chk;
  logic irq_chk;
  logic idle_chk;
  logic [31:0] exp_val;
  logic [31:0] mismatches;
  logic [31:0] lcg_state = 32'hff9d_64e7;
  row_t table_q[$];
  int timeouts = 0;

  safety_periph_top dut0 (.*);

  periph_checker chk0 (
    .clk_i       ( clk_i       ),
    .read_chk_i  ( read_chk    ),
    .rderr_chk_i ( rderr_chk   ),
    .irq_chk_i   ( irq_chk     ),
    .idle_chk_i  ( idle_chk    ),
    .exp_i       ( exp_val     ),
    .reg_rdata_i ( reg_rdata_o ),
    .reg_ready_i ( reg_ready_o ),
    .reg_error_i ( reg_error_o ),
    .core_irq_i  ( core_irq_o  ),
    .irq_id_i    ( irq_id_o    ),
    .irq_valid_i ( irq_valid_o ),
    .err_count_o ( mismatches  )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic add_row(input op_e op, input logic [31:0] addr, input logic [31:0] data,
                         input logic [1:0] err, input logic [31:0] exp);
    row_t r;
    r.op   = op;
    r.addr = addr;
    r.data = data;
    r.err  = err;
    r.exp  = exp;
    table_q.push_back(r);
  endtask

  task automatic build_table();
    logic [31:0] addr_a;
    logic [31:0] addr_b;
    logic [31:0] instr_addr [3];
    logic [31:0] instr_last;
    logic [1:0]  instr_codes [3];
    logic [7:0]  ext_pat;
    addr_a      = lcg_next() & ~32'h3;
    addr_b      = lcg_next() & ~32'h3;
    instr_codes = '{2'd1, 2'd3, 2'd2};
    for (int k = 0; k < 3; k++) begin
      instr_addr[k] = lcg_next() & ~32'h3;
    end
    instr_last = lcg_next() & ~32'h3;
    // Line 3 forced on so id 35 is the top enabled source
    ext_pat    = lcg_next() | 8'h08;
    // Reset state
    add_row(OP_IDLE_CHECK, 0, 0, 0, 0);
    add_row(OP_READ, IRQ_WIN + `IRQ_EN_LO_REG, 0, 0, 0);
    add_row(OP_READ, IRQ_WIN + `IRQ_EN_HI_REG, 0, 0, 0);
    // Decode
    add_row(OP_READ_ERR, `PERIPH_BASE_ADDR + 32'h300, 0, 0, 0);
    add_row(OP_READ_ERR, lcg_next() | 32'h8000_0000, 0, 0, 0);
    add_row(OP_READ, INSTR_WIN + `ERR_COUNT_REG, 0, 0, 0);
    // Data bus capture of the second completion
    add_row(OP_DATA_ACCEPT, addr_a, 0, 0, 0);
    add_row(OP_DATA_ACCEPT, addr_b, 0, 0, 0);
    add_row(OP_DATA_DONE, 0, 0, 2'd0, 0);
    add_row(OP_DATA_DONE, 0, 0, 2'd2, 0);
    add_row(OP_READ, DATA_WIN + `ERR_ADDR_REG, 0, 0, addr_b);
    add_row(OP_READ, DATA_WIN + `ERR_CODE_REG, 0, 0, 2);
    add_row(OP_READ, DATA_WIN + `ERR_COUNT_REG, 0, 0, 1);
    add_row(OP_READ, DATA_WIN + `ERR_STATUS_REG, 0, 0, 1);
    add_row(OP_READ, INSTR_WIN + `ERR_STATUS_REG, 0, 0, 0);
    // Counting keeps the first record
    for (int k = 0; k < 3; k++) begin
      add_row(OP_INSTR_ACCEPT, instr_addr[k], 0, 0, 0);
      add_row(OP_INSTR_DONE, 0, 0, instr_codes[k], 0);
    end
    add_row(OP_READ, INSTR_WIN + `ERR_COUNT_REG, 0, 0, 3);
    add_row(OP_READ, INSTR_WIN + `ERR_ADDR_REG, 0, 0, instr_addr[0]);
    add_row(OP_READ, INSTR_WIN + `ERR_CODE_REG, 0, 0, instr_codes[0]);
    add_row(OP_WRITE, INSTR_WIN + `ERR_STATUS_REG, 1, 0, 0);
    add_row(OP_READ, INSTR_WIN + `ERR_ADDR_REG, 0, 0, 0);
    add_row(OP_READ, INSTR_WIN + `ERR_CODE_REG, 0, 0, 0);
    add_row(OP_READ, INSTR_WIN + `ERR_COUNT_REG, 0, 0, 0);
    add_row(OP_READ, INSTR_WIN + `ERR_STATUS_REG, 0, 0, 0);
    // Masked sources, nothing enabled yet
    add_row(OP_EXT, 0, ext_pat, 0, 0);
    add_row(OP_NO_IRQ, 0, 0, 0, 0);
    // Selection, high enable first so 18 cannot win early
    add_row(OP_INSTR_ACCEPT, instr_last, 0, 0, 0);
    add_row(OP_INSTR_DONE, 0, 0, 2'd1, 0);
    add_row(OP_WRITE, IRQ_WIN + `IRQ_EN_HI_REG, 32'h1 << 3, 0, 0);
    add_row(OP_WRITE, IRQ_WIN + `IRQ_EN_LO_REG, 32'h1 << `IRQ_INSTR_ERR_BIT, 0, 0);
    add_row(OP_WAIT_IRQ, 0, 0, 0, `IRQ_EXT_BIT + 3);
    add_row(OP_EXT, 0, ext_pat & ~8'h08, 0, 0);
    add_row(OP_ACK, 0, 0, 0, 0);
    add_row(OP_WAIT_IRQ, 0, 0, 0, `IRQ_INSTR_ERR_BIT);
    add_row(OP_ACK, 0, 0, 0, 0);
  endtask

  task automatic clear_strobes();
    reg_valid_i    <= 1'b0;
    reg_write_i    <= 1'b0;
    instr_req_i    <= 1'b0;
    instr_gnt_i    <= 1'b0;
    instr_rvalid_i <= 1'b0;
    instr_err_i    <= '0;
    data_req_i     <= 1'b0;
    data_gnt_i     <= 1'b0;
    data_rvalid_i  <= 1'b0;
    data_err_i     <= '0;
    irq_ack_i      <= 1'b0;
    read_chk       <= 1'b0;
    rderr_chk      <= 1'b0;
    irq_chk        <= 1'b0;
    idle_chk       <= 1'b0;
  endtask

  task automatic apply_row(input row_t r);
    int waited;
    @(posedge clk_i);
    clear_strobes();
    exp_val <= r.exp;
    case (r.op)
      OP_READ, OP_READ_ERR: begin
        reg_valid_i <= 1'b1;
        reg_addr_i  <= r.addr;
        read_chk    <= (r.op == OP_READ);
        rderr_chk   <= (r.op == OP_READ_ERR);
      end
      OP_WRITE: begin
        reg_valid_i <= 1'b1;
        reg_write_i <= 1'b1;
        reg_addr_i  <= r.addr;
        reg_wdata_i <= r.data;
      end
      OP_DATA_ACCEPT: begin
        data_req_i  <= 1'b1;
        data_gnt_i  <= 1'b1;
        data_addr_i <= r.addr;
      end
      OP_DATA_DONE: begin
        data_rvalid_i <= 1'b1;
        data_err_i    <= r.err;
      end
      OP_INSTR_ACCEPT: begin
        instr_req_i  <= 1'b1;
        instr_gnt_i  <= 1'b1;
        instr_addr_i <= r.addr;
      end
      OP_INSTR_DONE: begin
        instr_rvalid_i <= 1'b1;
        instr_err_i    <= r.err;
      end
      OP_EXT:        ext_irqs_i <= r.data[`NUM_EXT_IRQ-1:0];
      OP_ACK:        irq_ack_i <= 1'b1;
      OP_IDLE_CHECK: idle_chk <= 1'b1;
      OP_NO_IRQ: begin
        idle_chk <= 1'b1;
        repeat (IRQ_TIMEOUT - 1) @(posedge clk_i);
      end
      default: begin
        waited = 0;
        @(negedge clk_i);
        while (!irq_valid_o && waited < IRQ_TIMEOUT) begin
          @(negedge clk_i);
          waited++;
        end
        if (irq_valid_o) begin
          @(posedge clk_i);
          irq_chk <= 1'b1;
        end else begin
          $display("timeout: irq_valid_o stayed low for %0d cycles", IRQ_TIMEOUT);
          timeouts++;
        end
      end
    endcase
  endtask

  initial begin
    rst_n_i      = 1'b0;
    reg_addr_i   = '0;
    reg_wdata_i  = '0;
    instr_addr_i = '0;
    data_addr_i  = '0;
    timer_irqs_i = '0;
    ext_irqs_i   = '0;
    exp_val      = '0;
    clear_strobes();
    build_table();
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    foreach (table_q[i]) begin
      apply_row(table_q[i]);
    end
    @(posedge clk_i);
    clear_strobes();
    repeat (2) @(posedge clk_i);
    $display("checks done: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* verification/periph_checker.sv */
// Compares DUT outputs at the falling edge while a strobe is high; one FAIL line per mismatch
`timescale 1ns/10ps
`include "periph_defines.svh"

module periph_checker (
  input  logic                    clk_i,
  input  logic                    read_chk_i,
  input  logic                    rderr_chk_i,
  input  logic                    irq_chk_i,
  input  logic                    idle_chk_i,
  input  logic [31:0]             exp_i,
  input  logic [31:0]             reg_rdata_i,
  input  logic                    reg_ready_i,
  input  logic                    reg_error_i,
  input  logic [`NUM_IRQ_SRC-1:0] core_irq_i,
  input  logic [`IRQ_ID_W-1:0]    irq_id_i,
  input  logic                    irq_valid_i,
  output logic [31:0]             err_count_o
);

  int                      errors = 0;
  logic [`NUM_IRQ_SRC-1:0] onehot;

  assign onehot      = {{(`NUM_IRQ_SRC-1){1'b0}}, 1'b1} << exp_i[`IRQ_ID_W-1:0];
  assign err_count_o = errors;

  task automatic compare_field(input string what, input logic [63:0] got,
                               input logic [63:0] want);
    if (got !== want) begin
      errors = errors + 1;
      $display("FAIL %0d ns: %s is %0h, expected %0h", $time, what, got, want);
    end
  endtask

  always @(negedge clk_i) begin
    if (read_chk_i) begin
      compare_field("reg_rdata_o", reg_rdata_i, exp_i);
      compare_field("reg_error_o", reg_error_i, 1'b0);
      compare_field("reg_ready_o", reg_ready_i, 1'b1);
    end
    if (rderr_chk_i) begin
      compare_field("reg_rdata_o", reg_rdata_i, exp_i);
      compare_field("reg_error_o", reg_error_i, 1'b1);
      compare_field("reg_ready_o", reg_ready_i, 1'b1);
    end
    // Presented interrupt must be one-hot at the expected id
    if (irq_chk_i) begin
      compare_field("irq_valid_o", irq_valid_i, 1'b1);
      compare_field("irq_id_o", irq_id_i, exp_i[`IRQ_ID_W-1:0]);
      compare_field("core_irq_o", core_irq_i, onehot);
    end
    if (idle_chk_i) begin
      compare_field("irq_valid_o", irq_valid_i, 1'b0);
      compare_field("core_irq_o", core_irq_i, '0);
    end
  end

endmodule

/* source/safety_periph_top.sv */
// Core-local peripherals without cores; register bus is always ready, bit 20 stays reserved
`timescale 1ns/10ps
`include "periph_defines.svh"

module safety_periph_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     reg_valid_i,
  input  logic                     reg_write_i,
  input  logic [31:0]              reg_addr_i,
  input  logic [31:0]              reg_wdata_i,
  input  logic                     instr_req_i,
  input  logic                     instr_gnt_i,
  input  logic                     instr_rvalid_i,
  input  logic [31:0]              instr_addr_i,
  input  logic [`BUS_ERR_BITS-1:0] instr_err_i,
  input  logic                     data_req_i,
  input  logic                     data_gnt_i,
  input  logic                     data_rvalid_i,
  input  logic [31:0]              data_addr_i,
  input  logic [`BUS_ERR_BITS-1:0] data_err_i,
  input  logic [1:0]               timer_irqs_i,
  input  logic [`NUM_EXT_IRQ-1:0]  ext_irqs_i,
  input  logic                     irq_ack_i,
  output logic [31:0]              reg_rdata_o,
  output logic                     reg_ready_o,
  output logic                     reg_error_o,
  output logic [`NUM_IRQ_SRC-1:0]  core_irq_o,
  output logic [`IRQ_ID_W-1:0]     irq_id_o,
  output logic                     irq_valid_o
);

  logic [`NUM_IRQ_SRC-1:0] irq_src;
  logic                    instr_err_irq;
  logic                    data_err_irq;

  mem_bus_if #(.ERR_W(`BUS_ERR_BITS)) instr_mem ();
  mem_bus_if #(.ERR_W(`BUS_ERR_BITS)) data_mem ();
  reg_bus_if #(.OFFSET_W(`REG_OFFSET_W)) irq_regs ();
  reg_bus_if #(.OFFSET_W(`REG_OFFSET_W)) instr_regs ();
  reg_bus_if #(.OFFSET_W(`REG_OFFSET_W)) data_regs ();

  assign instr_mem.req    = instr_req_i;
  assign instr_mem.gnt    = instr_gnt_i;
  assign instr_mem.rvalid = instr_rvalid_i;
  assign instr_mem.addr   = instr_addr_i;
  assign instr_mem.err    = instr_err_i;

  assign data_mem.req     = data_req_i;
  assign data_mem.gnt     = data_gnt_i;
  assign data_mem.rvalid  = data_rvalid_i;
  assign data_mem.addr    = data_addr_i;
  assign data_mem.err     = data_err_i;

  assign reg_ready_o = 1'b1;

  periph_regbus_demux demux0 (
    .reg_valid_i ( reg_valid_i ),
    .reg_write_i ( reg_write_i ),
    .reg_addr_i  ( reg_addr_i  ),
    .reg_wdata_i ( reg_wdata_i ),
    .reg_rdata_o ( reg_rdata_o ),
    .reg_error_o ( reg_error_o ),
    .irq_bus     ( irq_regs    ),
    .instr_bus   ( instr_regs  ),
    .data_bus    ( data_regs   )
  );

  bus_err_unit instr_err0 (
    .clk_i   ( clk_i         ),
    .rst_n_i ( rst_n_i       ),
    .bus     ( instr_mem     ),
    .regs    ( instr_regs    ),
    .irq_o   ( instr_err_irq )
  );

  bus_err_unit data_err0 (
    .clk_i   ( clk_i        ),
    .rst_n_i ( rst_n_i      ),
    .bus     ( data_mem     ),
    .regs    ( data_regs    ),
    .irq_o   ( data_err_irq )
  );

  // Numbering follows the core's local interrupt map
  always_comb begin
    irq_src                                = '0;
    irq_src[`IRQ_MTIP_BIT]                 = timer_irqs_i[0];
    irq_src[`IRQ_TIMER_BIT +: 2]           = timer_irqs_i;
    irq_src[`IRQ_INSTR_ERR_BIT]            = instr_err_irq;
    irq_src[`IRQ_DATA_ERR_BIT]             = data_err_irq;
    irq_src[`IRQ_EXT_BIT +: `NUM_EXT_IRQ]  = ext_irqs_i;
  end

  irq_ctrl irq_ctrl0 (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .src_i       ( irq_src     ),
    .irq_ack_i   ( irq_ack_i   ),
    .regs        ( irq_regs    ),
    .core_irq_o  ( core_irq_o  ),
    .irq_id_o    ( irq_id_o    ),
    .irq_valid_o ( irq_valid_o )
  );

endmodule

/* source/irq_ctrl.sv */
// Level sensitive interrupt controller; highest enabled id wins and is held until ack
`timescale 1ns/10ps
`include "periph_defines.svh"

module irq_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic [`NUM_IRQ_SRC-1:0] src_i,
  input  logic                    irq_ack_i,
  reg_bus_if.target               regs,
  output logic [`NUM_IRQ_SRC-1:0] core_irq_o,
  output logic [`IRQ_ID_W-1:0]    irq_id_o,
  output logic                    irq_valid_o
);

  logic [31:0]                 en_lo_q;
  logic [`NUM_IRQ_SRC-33:0]    en_hi_q;
  logic [`NUM_IRQ_SRC-1:0]     active;
  logic [`IRQ_ID_W-1:0]        best_id;
  logic [`IRQ_ID_W-1:0]        id_q;
  logic                        wr_en;
  periph_pkg::irq_state_e      state_q;

  assign wr_en = regs.valid && regs.write;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      en_lo_q <= '0;
      en_hi_q <= '0;
    end else if (wr_en && (regs.offset == `IRQ_EN_LO_REG)) begin
      en_lo_q <= regs.wdata;
    end else if (wr_en && (regs.offset == `IRQ_EN_HI_REG)) begin
      en_hi_q <= regs.wdata[`NUM_IRQ_SRC-33:0];
    end
  end

  always_comb begin
    regs.rdata = '0;
    regs.error = 1'b0;
    case (regs.offset)
      `IRQ_EN_LO_REG: regs.rdata = en_lo_q;
      `IRQ_EN_HI_REG: regs.rdata = {{(64-`NUM_IRQ_SRC){1'b0}}, en_hi_q};
      default:        regs.error = regs.valid;
    endcase
  end

  assign active = src_i & {en_hi_q, en_lo_q};

  // Later ids overwrite earlier ones
  always_comb begin
    best_id = '0;
    for (int i = 0; i < `NUM_IRQ_SRC; i++) begin
      if (active[i]) begin
        best_id = i[`IRQ_ID_W-1:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= periph_pkg::IRQ_IDLE;
      id_q    <= '0;
    end else begin
      case (state_q)
        periph_pkg::IRQ_IDLE: begin
          if (active != '0) begin
            id_q    <= best_id;
            state_q <= periph_pkg::IRQ_PRESENT;
          end
        end
        default: begin
          if (irq_ack_i) begin
            state_q <= periph_pkg::IRQ_IDLE;
          end
        end
      endcase
    end
  end

  assign irq_valid_o = (state_q == periph_pkg::IRQ_PRESENT);
  assign irq_id_o    = id_q;

  always_comb begin
    core_irq_o = '0;
    if (irq_valid_o) begin
      core_irq_o[id_q] = 1'b1;
    end
  end

endmodule

/* source/bus_err_unit.sv */
// Memory bus error monitor; keeps only the first error, an error in the clearing cycle is lost
`timescale 1ns/10ps
`include "periph_defines.svh"

module bus_err_unit (
  input  logic       clk_i,
  input  logic       rst_n_i,
  mem_bus_if.monitor bus,
  reg_bus_if.target  regs,
  output logic       irq_o
);

  logic                     accept;
  logic                     err_done;
  logic [31:0]              head_addr;
  logic                     pending;
  logic [31:0]              err_addr_q;
  logic [`BUS_ERR_BITS-1:0] err_code_q;
  logic [`ERR_COUNT_W-1:0]  err_count_q;
  logic                     clear;
  logic                     reg_hit;
  periph_pkg::err_reg_e     reg_sel;

  assign accept   = bus.req && bus.gnt;
  assign err_done = bus.rvalid && (bus.err != '0);

  outstanding_tracker #(
    .DEPTH       ( `NUM_OUTSTANDING )
  ) tracker0 (
    .clk_i       ( clk_i      ),
    .rst_n_i     ( rst_n_i    ),
    .push_i      ( accept     ),
    .push_addr_i ( bus.addr   ),
    .pop_i       ( bus.rvalid ),
    .head_addr_o ( head_addr  )
  );

  always_comb begin
    reg_hit = 1'b1;
    case (regs.offset)
      `ERR_ADDR_REG:   reg_sel = periph_pkg::ERR_ADDR;
      `ERR_CODE_REG:   reg_sel = periph_pkg::ERR_CODE;
      `ERR_COUNT_REG:  reg_sel = periph_pkg::ERR_COUNT;
      `ERR_STATUS_REG: reg_sel = periph_pkg::ERR_STATUS;
      default: begin
        reg_sel = periph_pkg::ERR_ADDR;
        reg_hit = 1'b0;
      end
    endcase
  end

  assign clear = regs.valid && regs.write && reg_hit &&
                 (reg_sel == periph_pkg::ERR_STATUS) && regs.wdata[0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear) begin
      pending     <= 1'b0;
      err_addr_q  <= '0;
      err_code_q  <= '0;
      err_count_q <= '0;
    end else if (err_done) begin
      // Record only the first error
      if (!pending) begin
        pending    <= 1'b1;
        err_addr_q <= head_addr;
        err_code_q <= bus.err;
      end
      if (err_count_q != '1) begin
        err_count_q <= err_count_q + 1'b1;
      end
    end
  end

  always_comb begin
    regs.rdata = '0;
    if (reg_hit) begin
      case (reg_sel)
        periph_pkg::ERR_ADDR:  regs.rdata = err_addr_q;
        periph_pkg::ERR_CODE:  regs.rdata = {{(32-`BUS_ERR_BITS){1'b0}}, err_code_q};
        periph_pkg::ERR_COUNT: regs.rdata = {{(32-`ERR_COUNT_W){1'b0}}, err_count_q};
        default:               regs.rdata = {31'b0, pending};
      endcase
    end
  end

  assign regs.error = regs.valid && !reg_hit;
  assign irq_o      = pending;

endmodule

/* source/outstanding_tracker.sv */
// In-order address queue for granted transactions; a push while full and not popping is dropped
`timescale 1ns/10ps

module outstanding_tracker #(
  parameter int DEPTH = 2
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        push_i,
  input  logic [31:0] push_addr_i,
  input  logic        pop_i,
  output logic [31:0] head_addr_o
);

  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [31:0]      queue [DEPTH];
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] wr_idx;
  logic             push_ok;
  logic             pop_ok;

  assign pop_ok  = pop_i && (count != '0);
  assign push_ok = push_i && ((count != CNT_W'(DEPTH)) || pop_ok);
  // A pop shifts the queue, so the free slot moves down by one
  assign wr_idx  = pop_ok ? count - 1'b1 : count;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count <= '0;
    end else if (push_ok && !pop_ok) begin
      count <= count + 1'b1;
    end else if (pop_ok && !push_ok) begin
      count <= count - 1'b1;
    end
  end

  for (genvar i = 0; i < DEPTH; i++) begin : g_entry
    logic [31:0] shift_in;

    if (i < DEPTH - 1) begin : g_mid
      assign shift_in = queue[i+1];
    end else begin : g_last
      assign shift_in = queue[i];
    end

    always_ff @(posedge clk_i) begin
      if (push_ok && (wr_idx == CNT_W'(i))) begin
        queue[i] <= push_addr_i;
      end else if (pop_ok) begin
        queue[i] <= shift_in;
      end
    end
  end

  assign head_addr_o = queue[0];

endmodule

/* source/periph_regbus_demux.sv */
// Combinational register bus decoder; unmapped addresses answer error 1 and rdata 0
`timescale 1ns/10ps
`include "periph_defines.svh"

module periph_regbus_demux (
  input  logic         reg_valid_i,
  input  logic         reg_write_i,
  input  logic [31:0]  reg_addr_i,
  input  logic [31:0]  reg_wdata_i,
  output logic [31:0]  reg_rdata_o,
  output logic         reg_error_o,
  reg_bus_if.initiator irq_bus,
  reg_bus_if.initiator instr_bus,
  reg_bus_if.initiator data_bus
);

  periph_pkg::periph_sel_e sel;
  logic [31:0]             win_base;
  logic [31:0]             win_offset;

  // Wrapping subtraction makes addresses below the base fall outside
  function automatic logic in_window(logic [31:0] addr, logic [31:0] base);
    logic [31:0] diff;
    diff = addr - base;
    return diff < `TARGET_RANGE;
  endfunction

  always_comb begin
    sel      = periph_pkg::SEL_NONE;
    win_base = `PERIPH_BASE_ADDR;
    if (in_window(reg_addr_i, `PERIPH_BASE_ADDR + `IRQ_CTRL_OFFSET)) begin
      sel      = periph_pkg::SEL_IRQ;
      win_base = `PERIPH_BASE_ADDR + `IRQ_CTRL_OFFSET;
    end else if (in_window(reg_addr_i, `PERIPH_BASE_ADDR + `INSTR_ERR_OFFSET)) begin
      sel      = periph_pkg::SEL_INSTR_ERR;
      win_base = `PERIPH_BASE_ADDR + `INSTR_ERR_OFFSET;
    end else if (in_window(reg_addr_i, `PERIPH_BASE_ADDR + `DATA_ERR_OFFSET)) begin
      sel      = periph_pkg::SEL_DATA_ERR;
      win_base = `PERIPH_BASE_ADDR + `DATA_ERR_OFFSET;
    end
  end

  assign win_offset = reg_addr_i - win_base;

  // Only the selected target sees valid
  assign irq_bus.valid    = reg_valid_i && (sel == periph_pkg::SEL_IRQ);
  assign irq_bus.write    = reg_write_i;
  assign irq_bus.offset   = win_offset[`REG_OFFSET_W-1:0];
  assign irq_bus.wdata    = reg_wdata_i;

  assign instr_bus.valid  = reg_valid_i && (sel == periph_pkg::SEL_INSTR_ERR);
  assign instr_bus.write  = reg_write_i;
  assign instr_bus.offset = win_offset[`REG_OFFSET_W-1:0];
  assign instr_bus.wdata  = reg_wdata_i;

  assign data_bus.valid   = reg_valid_i && (sel == periph_pkg::SEL_DATA_ERR);
  assign data_bus.write   = reg_write_i;
  assign data_bus.offset  = win_offset[`REG_OFFSET_W-1:0];
  assign data_bus.wdata   = reg_wdata_i;

  always_comb begin
    case (sel)
      periph_pkg::SEL_IRQ: begin
        reg_rdata_o = irq_bus.rdata;
        reg_error_o = irq_bus.error;
      end
      periph_pkg::SEL_INSTR_ERR: begin
        reg_rdata_o = instr_bus.rdata;
        reg_error_o = instr_bus.error;
      end
      periph_pkg::SEL_DATA_ERR: begin
        reg_rdata_o = data_bus.rdata;
        reg_error_o = data_bus.error;
      end
      default: begin
        reg_rdata_o = '0;
        reg_error_o = 1'b1;
      end
    endcase
  end

endmodule

/* source/reg_bus_if.sv */
// One register bus target; always ready, rdata and error are combinational
`timescale 1ns/10ps

interface reg_bus_if #(
  parameter int OFFSET_W = 8
) ();

  logic                valid;
  logic                write;
  logic [OFFSET_W-1:0] offset;
  logic [31:0]         wdata;
  logic [31:0]         rdata;
  logic                error;

  modport initiator (output valid, write, offset, wdata, input rdata, error);

  modport target (input valid, write, offset, wdata, output rdata, error);

endinterface

/* source/mem_bus_if.sv */
// One memory bus as seen by a monitor; completions are in order, err valid with rvalid
`timescale 1ns/10ps

interface mem_bus_if #(
  parameter int ERR_W = 2
) ();

  logic             req;
  logic             gnt;
  logic             rvalid;
  logic [31:0]      addr;
  logic [ERR_W-1:0] err;

  // Passive observer
  modport monitor (input req, gnt, rvalid, addr, err);

  modport source (output req, gnt, rvalid, addr, err);

endinterface

/* source/periph_pkg.sv */
// Enum types for the peripheral block; encodings are fixed by the register map
package periph_pkg;

  // Register bus target
  typedef enum logic [1:0] {
    SEL_IRQ,
    SEL_INSTR_ERR,
    SEL_DATA_ERR,
    SEL_NONE
  } periph_sel_e;

  // Monitor registers, in offset order
  typedef enum logic [1:0] {
    ERR_ADDR,
    ERR_CODE,
    ERR_COUNT,
    ERR_STATUS
  } err_reg_e;

  typedef enum logic {
    IRQ_IDLE,
    IRQ_PRESENT
  } irq_state_e;

endpackage

/* source/periph_defines.svh */
// Address map, widths and interrupt numbering; windows are assumed 0x100 aligned
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// Register bus map
`define PERIPH_BASE_ADDR  32'h0020_0000
`define IRQ_CTRL_OFFSET   32'h0000_0000
`define INSTR_ERR_OFFSET  32'h0000_0100
`define DATA_ERR_OFFSET   32'h0000_0200
`define TARGET_RANGE      32'h0000_0100
`define REG_OFFSET_W      8

// Offsets inside a bus error window
`define ERR_ADDR_REG      8'h00
`define ERR_CODE_REG      8'h04
`define ERR_COUNT_REG     8'h08
`define ERR_STATUS_REG    8'h0C

// Offsets inside the interrupt controller window
`define IRQ_EN_LO_REG     8'h00
`define IRQ_EN_HI_REG     8'h04

`define BUS_ERR_BITS      2
`define NUM_OUTSTANDING   2
`define ERR_COUNT_W       8
`define NUM_EXT_IRQ       8
`define NUM_IRQ_SRC       40
`define IRQ_ID_W          6

// Source vector numbering
`define IRQ_MTIP_BIT      7
`define IRQ_TIMER_BIT     16
`define IRQ_INSTR_ERR_BIT 18
`define IRQ_DATA_ERR_BIT  19
`define IRQ_EXT_BIT       32

`endif
